/* ex_stage.f */
logic/ex_pkg.sv
logic/ex_result_if.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_result_reg.sv
logic/ex_stage.sv
tb/tb_clk_gen.sv
tb/tb_ex_stage.sv

/* tb/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage;

    typedef struct {
        ex_pkg::inst_t     inst;
        ex_pkg::word_t     reg2;
        ex_pkg::word_t     op1;
        ex_pkg::word_t     op2;
        ex_pkg::word_t     op1_jump;
        ex_pkg::word_t     op2_jump;
        logic              we;
        ex_pkg::reg_addr_t waddr;
        ex_pkg::word_t     exp_wdata;
        logic              exp_jump;
        ex_pkg::word_t     exp_jaddr;
    } row_t;

    logic              clk;
    logic              rst_i;
    ex_pkg::inst_t     inst;
    ex_pkg::word_t     reg2;
    ex_pkg::word_t     op1;
    ex_pkg::word_t     op2;
    ex_pkg::word_t     op1_jump;
    ex_pkg::word_t     op2_jump;
    logic              reg_we;
    ex_pkg::reg_addr_t reg_waddr;
    ex_pkg::word_t     reg_wdata_o;
    logic              reg_we_o;
    ex_pkg::reg_addr_t reg_waddr_o;
    logic              jump_flag_o;
    ex_pkg::word_t     jump_addr_o;

    row_t   rows[$];
    row_t   rnd;
    integer seed;
    integer draw;
    int     settled_edges = 0;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_i (rst_i)
    );

    ex_stage i_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_i       (inst),
        .reg2_rdata_i (reg2),
        .op1_i        (op1),
        .op2_i        (op2),
        .op1_jump_i   (op1_jump),
        .op2_jump_i   (op2_jump),
        .reg_we_i     (reg_we),
        .reg_waddr_i  (reg_waddr),
        .reg_wdata_o  (reg_wdata_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o)
    );

    // counts edges 1.25 ns late, once the register outputs have settled
    always @(posedge clk) begin
        #1.25;
        settled_edges = settled_edges + 1;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // polls on the half-ns grid, so never in the same step as the counter
    task automatic wait_edge();
        int target;
        int polls;
        target = settled_edges + 1;
        polls = 0;
        while (settled_edges < target && polls < 200) begin
            #0.5;
            polls++;
        end
        if (settled_edges < target) begin
            abort_run("timed out waiting for the next clock edge");
        end
    endtask

    task automatic wait_reset_release();
        int polls;
        polls = 0;
        while (rst_i && polls < 600) begin
            #0.5;
            polls++;
        end
        if (rst_i) begin
            abort_run("timed out waiting for reset to be released");
        end
    endtask

    task automatic check_wdata(input ex_pkg::word_t exp, input string what);
        if (reg_wdata_o !== exp) begin
            abort_run($sformatf("Error @%0t: %s write data %h, expected %h",
                                $time, what, reg_wdata_o, exp));
        end
    endtask

    task automatic check_jump(input logic exp_flag, input ex_pkg::word_t exp_addr,
                              input string what);
        if (jump_flag_o !== exp_flag || jump_addr_o !== exp_addr) begin
            abort_run($sformatf("Error @%0t: %s jump %b/%h, expected %b/%h", $time,
                                what, jump_flag_o, jump_addr_o, exp_flag, exp_addr));
        end
    endtask

    task automatic check_write(input logic exp_we, input ex_pkg::reg_addr_t exp_addr,
                               input string what);
        if (reg_we_o !== exp_we || reg_waddr_o !== exp_addr) begin
            abort_run($sformatf("Error @%0t: %s write enable/addr %b/%0d, expected %b/%0d",
                                $time, what, reg_we_o, reg_waddr_o, exp_we, exp_addr));
        end
    endtask

    function automatic ex_pkg::inst_t enc_r(input logic alt, input logic [2:0] f3);
        ex_pkg::inst_t w;
        w.r.funct7 = alt ? ex_pkg::F7_ALT : ex_pkg::F7_BASE;
        w.r.rs2    = 5'd2;
        w.r.rs1    = 5'd1;
        w.r.funct3 = f3;
        w.r.rd     = 5'd3;
        w.r.opcode = ex_pkg::OP_REG;
        return w;
    endfunction

    function automatic ex_pkg::inst_t enc_i(input logic [11:0] imm, input logic [2:0] f3);
        ex_pkg::inst_t w;
        w.i.imm    = imm;
        w.i.rs1    = 5'd4;
        w.i.funct3 = f3;
        w.i.rd     = 5'd5;
        w.i.opcode = ex_pkg::OP_IMM;
        return w;
    endfunction

    // upper bits hold an offset the stage does not look at
    function automatic ex_pkg::inst_t enc_op(input logic [6:0] opcode, input logic [2:0] f3);
        ex_pkg::inst_t w;
        w = 32'h5a5a_5000;
        w.r.funct3 = f3;
        w.r.opcode = opcode;
        return w;
    endfunction

    // RV32I register-register results
    function automatic ex_pkg::word_t model_rtype(input logic alt, input logic [2:0] f3,
                                                  input ex_pkg::word_t a,
                                                  input ex_pkg::word_t b);
        ex_pkg::shamt_t sh;
        ex_pkg::word_t  fill;
        sh = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (f3)
            ex_pkg::F3_ADD_SUB: return alt ? a - b : a + b;
            ex_pkg::F3_SLL:     return a << sh;
            ex_pkg::F3_SLT:     return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 1 : 0;
            ex_pkg::F3_SLTU:    return (a < b) ? 1 : 0;
            ex_pkg::F3_XOR:     return a ^ b;
            ex_pkg::F3_SR:      return alt ? ((a >> sh) | fill) : (a >> sh);
            ex_pkg::F3_OR:      return a | b;
            default:            return a & b;
        endcase
    endfunction

    task automatic add_row(input ex_pkg::inst_t i, input ex_pkg::word_t r2,
                           input ex_pkg::word_t a, input ex_pkg::word_t b,
                           input ex_pkg::word_t j1, input ex_pkg::word_t j2,
                           input logic we, input ex_pkg::reg_addr_t wa,
                           input ex_pkg::word_t exp_w, input logic exp_j,
                           input ex_pkg::word_t exp_ja);
        row_t r;
        r.inst      = i;
        r.reg2      = r2;
        r.op1       = a;
        r.op2       = b;
        r.op1_jump  = j1;
        r.op2_jump  = j2;
        r.we        = we;
        r.waddr     = wa;
        r.exp_wdata = exp_w;
        r.exp_jump  = exp_j;
        r.exp_jaddr = exp_ja;
        rows.push_back(r);
    endtask

    // op2 doubles as reg2, jump operands present but not taken
    task automatic alu_row(input ex_pkg::inst_t i, input ex_pkg::word_t a,
                           input ex_pkg::word_t b, input ex_pkg::reg_addr_t wa,
                           input ex_pkg::word_t exp_w);
        add_row(i, b, a, b, 32'h40, 32'h4, 1'b1, wa, exp_w, 1'b0, 32'h0);
    endtask

    // target 0x1000 + 0x20
    task automatic br_row(input logic [2:0] f3, input ex_pkg::word_t a,
                          input ex_pkg::word_t b, input logic taken);
        add_row(enc_op(ex_pkg::OP_BRANCH, f3), b, a, b, 32'h1000, 32'h20, 1'b0, 5'd0,
                32'h0, taken, taken ? 32'h0000_1020 : 32'h0);
    endtask

    task automatic build_table();
        alu_row(enc_r(1'b0, ex_pkg::F3_ADD_SUB), 32'h5, 32'h7, 5'd1, 32'hc);
        alu_row(enc_r(1'b1, ex_pkg::F3_ADD_SUB), 32'h5, 32'h7, 5'd2, 32'hffff_fffe);
        alu_row(enc_r(1'b0, ex_pkg::F3_XOR), 32'hf0f0_1234, 32'h0ff0_ffff, 5'd3,
                32'hff00_edcb);
        alu_row(enc_r(1'b0, ex_pkg::F3_OR), 32'hf000_000f, 32'hff00, 5'd4, 32'hf000_ff0f);
        alu_row(enc_r(1'b0, ex_pkg::F3_AND), 32'hffff_0000, 32'h1234_5678, 5'd5,
                32'h1234_0000);
        alu_row(enc_r(1'b0, ex_pkg::F3_SLT), 32'hffff_ffff, 32'h1, 5'd6, 32'h1);
        alu_row(enc_r(1'b0, ex_pkg::F3_SLTU), 32'hffff_ffff, 32'h1, 5'd7, 32'h0);
        alu_row(enc_i(12'hfff, ex_pkg::F3_ADD_SUB), 32'ha, 32'hffff_ffff, 5'd8, 32'h9);
        alu_row(enc_i(12'h000, ex_pkg::F3_SLT), 32'h8000_0000, 32'h0, 5'd9, 32'h1);
        alu_row(enc_i(12'h000, ex_pkg::F3_SLTU), 32'h8000_0000, 32'h0, 5'd10, 32'h0);
        alu_row(enc_i(12'hf0f, ex_pkg::F3_XOR), 32'hff, 32'hffff_ff0f, 5'd11, 32'hffff_fff0);
        alu_row(enc_i(12'h034, ex_pkg::F3_OR), 32'h1200_0000, 32'h34, 5'd12, 32'h1200_0034);
        alu_row(enc_i(12'hff0, ex_pkg::F3_AND), 32'hdead_beef, 32'hff0, 5'd13, 32'hee0);
        // immediate shifts, reg2 low bits differ from the immediate
        alu_row(enc_i(12'h004, ex_pkg::F3_SLL), 32'h0f0f, 32'h1f, 5'd14, 32'hf0f0);
        alu_row(enc_i(12'h008, ex_pkg::F3_SR), 32'h8000_1200, 32'h1f, 5'd15, 32'h0080_0012);
        alu_row(enc_i(12'h408, ex_pkg::F3_SR), 32'h8000_1200, 32'h1f, 5'd16, 32'hff80_0012);
        alu_row(enc_r(1'b0, ex_pkg::F3_SLL), 32'h3, 32'h24, 5'd17, 32'h30);
        alu_row(enc_r(1'b0, ex_pkg::F3_SR), 32'h8000_0000, 32'hffff_ffe1, 5'd18,
                32'h4000_0000);
        alu_row(enc_r(1'b1, ex_pkg::F3_SR), 32'h8000_0000, 32'h1f, 5'd19, 32'hffff_ffff);
        alu_row(enc_r(1'b1, ex_pkg::F3_SR), 32'h7000_0000, 32'h4, 5'd20, 32'h0700_0000);
        // -2 against 1: signed and unsigned orders disagree
        br_row(ex_pkg::F3_BEQ, 32'h55, 32'h55, 1'b1);
        br_row(ex_pkg::F3_BEQ, 32'hffff_fffe, 32'h1, 1'b0);
        br_row(ex_pkg::F3_BNE, 32'hffff_fffe, 32'h1, 1'b1);
        br_row(ex_pkg::F3_BNE, 32'h55, 32'h55, 1'b0);
        br_row(ex_pkg::F3_BLT, 32'hffff_fffe, 32'h1, 1'b1);
        br_row(ex_pkg::F3_BLT, 32'h1, 32'hffff_fffe, 1'b0);
        br_row(ex_pkg::F3_BGE, 32'h1, 32'hffff_fffe, 1'b1);
        br_row(ex_pkg::F3_BGE, 32'hffff_fffe, 32'h1, 1'b0);
        br_row(ex_pkg::F3_BLTU, 32'h1, 32'hffff_fffe, 1'b1);
        br_row(ex_pkg::F3_BLTU, 32'hffff_fffe, 32'h1, 1'b0);
        br_row(ex_pkg::F3_BGEU, 32'hffff_fffe, 32'h1, 1'b1);
        br_row(ex_pkg::F3_BGEU, 32'h1, 32'hffff_fffe, 1'b0);
        add_row(enc_op(ex_pkg::OP_JAL, 3'b000), 32'h0, 32'h2000, 32'h4, 32'h2000, 32'h100,
                1'b1, 5'd1, 32'h2004, 1'b1, 32'h2100);
        add_row(enc_op(ex_pkg::OP_JALR, 3'b000), 32'h0, 32'h3000, 32'h4, 32'h4000,
                32'hffff_fff0, 1'b1, 5'd21, 32'h3004, 1'b1, 32'h3ff0);
        add_row(enc_op(ex_pkg::OP_LUI, 3'b010), 32'h0, 32'h0, 32'h1234_5000, 32'h40, 32'h4,
                1'b1, 5'd22, 32'h1234_5000, 1'b0, 32'h0);
        add_row(enc_op(ex_pkg::OP_AUIPC, 3'b110), 32'h0, 32'h8000, 32'habcd_e000, 32'h40,
                32'h4, 1'b1, 5'd23, 32'habce_6000, 1'b0, 32'h0);
        // load opcode is not handled here
        add_row(enc_op(7'b0000011, 3'b010), 32'h6, 32'h5, 32'h6, 32'h40, 32'h4,
                1'b1, 5'd24, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic drive_row(input row_t r);
        #0.5;
        inst      = r.inst;
        reg2      = r.reg2;
        op1       = r.op1;
        op2       = r.op2;
        op1_jump  = r.op1_jump;
        op2_jump  = r.op2_jump;
        reg_we    = r.we;
        reg_waddr = r.waddr;
    endtask

    // entered 1.5 ns after an edge, inputs change 2 ns after it
    task automatic apply_row(input row_t r, input string what);
        drive_row(r);
        wait_edge();
        check_wdata(r.exp_wdata, what);
        check_jump(r.exp_jump, r.exp_jaddr, what);
        check_write(r.we, r.waddr, what);
    endtask

    task automatic check_cleared(input string what);
        check_wdata(32'h0, what);
        check_jump(1'b0, 32'h0, what);
        check_write(1'b0, 5'd0, what);
    endtask

    initial begin
        seed = 32'h0062_f56d;
        // a JAL sits on the inputs all through reset
        inst      = enc_op(ex_pkg::OP_JAL, 3'b000);
        reg2      = 32'h0;
        op1       = 32'h1;
        op2       = 32'h2;
        op1_jump  = 32'h10;
        op2_jump  = 32'h20;
        reg_we    = 1'b1;
        reg_waddr = 5'd7;
        build_table();
        wait_edge();
        check_cleared("during reset");
        wait_reset_release();
        check_cleared("cycle after reset");
        wait_edge();
        check_wdata(32'h3, "first after reset");
        check_jump(1'b1, 32'h30, "first after reset");
        check_write(1'b1, 5'd7, "first after reset");
        foreach (rows[n]) begin
            apply_row(rows[n], $sformatf("row %0d", n));
        end
        for (int n = 0; n < 40; n++) begin
            draw          = $random(seed);
            rnd.inst      = enc_r(draw[3] && (draw[2:0] == ex_pkg::F3_ADD_SUB ||
                                              draw[2:0] == ex_pkg::F3_SR), draw[2:0]);
            rnd.op1       = $random(seed);
            rnd.op2       = $random(seed);
            rnd.reg2      = rnd.op2;
            rnd.op1_jump  = $random(seed);
            rnd.op2_jump  = $random(seed);
            rnd.we        = draw[9];
            rnd.waddr     = draw[8:4];
            rnd.exp_wdata = model_rtype(rnd.inst.r.funct7 == ex_pkg::F7_ALT, draw[2:0],
                                        rnd.op1, rnd.op2);
            rnd.exp_jump  = 1'b0;
            rnd.exp_jaddr = 32'h0;
            apply_row(rnd, $sformatf("random %0d", n));
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_i
);

    // 40 ns period, first rising edge at 20 ns
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // high over the edges at 20, 60 and 100 ns, released 2 ns after the third
    initial begin
        rst_i = 1'b1;
        #102;
        rst_i = 1'b0;
    end

endmodule

/* logic/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  ex_pkg::inst_t     inst_i,
    input  ex_pkg::word_t     reg2_rdata_i,
    input  ex_pkg::word_t     op1_i,
    input  ex_pkg::word_t     op2_i,
    input  ex_pkg::word_t     op1_jump_i,
    input  ex_pkg::word_t     op2_jump_i,
    input  logic              reg_we_i,
    input  ex_pkg::reg_addr_t reg_waddr_i,
    output ex_pkg::word_t     reg_wdata_o,
    output logic              reg_we_o,
    output ex_pkg::reg_addr_t reg_waddr_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);

    ex_pkg::alu_op_e  alu_op;
    ex_pkg::br_cond_e br_cond;
    ex_pkg::shamt_t   shamt;

    ex_result_if res_if ();

    ex_decode i_decode (
        .inst_i       (inst_i),
        .reg2_rdata_i (reg2_rdata_i),
        .alu_op_o     (alu_op),
        .br_cond_o    (br_cond),
        .shamt_o      (shamt)
    );

    ex_alu i_alu (
        .alu_op_i    (alu_op),
        .br_cond_i   (br_cond),
        .shamt_i     (shamt),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .op1_jump_i  (op1_jump_i),
        .op2_jump_i  (op2_jump_i),
        .reg_we_i    (reg_we_i),
        .reg_waddr_i (reg_waddr_i),
        .res_o       (res_if.alu)
    );

    // pipeline register closes the stage
    ex_result_reg i_result_reg (
        .clk         (clk),
        .rst_i       (rst_i),
        .res_i       (res_if.reg_stage),
        .reg_wdata_o (reg_wdata_o),
        .jump_addr_o (jump_addr_o),
        .reg_we_o    (reg_we_o),
        .jump_flag_o (jump_flag_o),
        .reg_waddr_o (reg_waddr_o)
    );

endmodule

/* logic/ex_result_reg.sv */
`timescale 1ns/1ps

module ex_result_reg (
    input  logic              clk,
    input  logic              rst_i,
    ex_result_if.reg_stage    res_i,
    output ex_pkg::word_t     reg_wdata_o,
    output ex_pkg::word_t     jump_addr_o,
    output logic              reg_we_o,
    output logic              jump_flag_o,
    output ex_pkg::reg_addr_t reg_waddr_o
);

    // stage boundary, results show one clock after their inputs
    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_wdata_o <= '0;
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            reg_wdata_o <= res_i.wdata;
            reg_we_o    <= res_i.we;
            reg_waddr_o <= res_i.waddr;
            jump_flag_o <= res_i.jump;
            jump_addr_o <= res_i.jump_addr;
        end
    end

    // nothing is written or taken in the cycle following a reset cycle
    a_reset_quiet: assert property (
        @(posedge clk) rst_i |=> (!reg_we_o && !jump_flag_o)
    ) else $error("flags active right after reset");

    // the ALU only presents a target together with a taken jump
    a_addr_masked: assert property (
        @(posedge clk) disable iff (rst_i)
        !jump_flag_o |-> (jump_addr_o == '0)
    ) else $error("jump address %h without jump flag", jump_addr_o);

endmodule

/* logic/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::alu_op_e   alu_op_i,
    input  ex_pkg::br_cond_e  br_cond_i,
    input  ex_pkg::shamt_t    shamt_i,
    input  ex_pkg::word_t     op1_i,
    input  ex_pkg::word_t     op2_i,
    input  ex_pkg::word_t     op1_jump_i,
    input  ex_pkg::word_t     op2_jump_i,
    input  logic              reg_we_i,
    input  ex_pkg::reg_addr_t reg_waddr_i,
    ex_result_if.alu          res_o
);

    ex_pkg::word_t add_res;
    ex_pkg::word_t sub_res;
    ex_pkg::word_t sra_res;
    ex_pkg::word_t jump_sum;
    ex_pkg::word_t wdata;
    logic          lt_s;
    logic          lt_u;
    logic          eq;
    logic          take;

    assign add_res  = op1_i + op2_i;
    assign sub_res  = op1_i - op2_i;
    assign jump_sum = op1_jump_i + op2_jump_i;

    // sign bit fills from the left
    assign sra_res = ex_pkg::word_t'($signed(op1_i) >>> shamt_i);

    // shared by SLT/SLTU and the branches
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;
    assign eq   = (op1_i == op2_i);

    always_comb begin
        case (alu_op_i)
            ex_pkg::ALU_ADD:  wdata = add_res;
            ex_pkg::ALU_SUB:  wdata = sub_res;
            ex_pkg::ALU_SLL:  wdata = op1_i << shamt_i;
            ex_pkg::ALU_SLT:  wdata = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
            ex_pkg::ALU_SLTU: wdata = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
            ex_pkg::ALU_XOR:  wdata = op1_i ^ op2_i;
            ex_pkg::ALU_SRL:  wdata = op1_i >> shamt_i;
            ex_pkg::ALU_SRA:  wdata = sra_res;
            ex_pkg::ALU_OR:   wdata = op1_i | op2_i;
            ex_pkg::ALU_AND:  wdata = op1_i & op2_i;
            default:          wdata = '0;
        endcase
    end

    always_comb begin
        case (br_cond_i)
            ex_pkg::BR_ALWAYS: take = 1'b1;
            ex_pkg::BR_EQ:     take = eq;
            ex_pkg::BR_NE:     take = !eq;
            ex_pkg::BR_LT:     take = lt_s;
            ex_pkg::BR_GE:     take = !lt_s;
            ex_pkg::BR_LTU:    take = lt_u;
            ex_pkg::BR_GEU:    take = !lt_u;
            default:           take = 1'b0;
        endcase
    end

    assign res_o.wdata = wdata;
    assign res_o.we    = reg_we_i;
    assign res_o.waddr = reg_waddr_i;
    assign res_o.jump  = take;

    // target is masked when no jump is taken
    assign res_o.jump_addr = take ? jump_sum : '0;

    // non-jump instructions must not reach the bundle as a jump
    always_comb begin
        if (br_cond_i == ex_pkg::BR_NEVER) begin
            assert final (!res_o.jump && (res_o.jump_addr == '0))
                else $error("jump raised for a non-jump instruction");
        end
    end

endmodule

/* logic/ex_decode.sv */
`timescale 1ns/1ps

module ex_decode (
    input  ex_pkg::inst_t    inst_i,
    input  ex_pkg::word_t    reg2_rdata_i,
    output ex_pkg::alu_op_e  alu_op_o,
    output ex_pkg::br_cond_e br_cond_o,
    output ex_pkg::shamt_t   shamt_o
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic           f7_base;
    logic           f7_alt;
    ex_pkg::shamt_t imm_shamt;
    ex_pkg::shamt_t reg_shamt;

    assign opcode  = inst_i.r.opcode;
    assign funct3  = inst_i.r.funct3;
    assign f7_base = (inst_i.r.funct7 == ex_pkg::F7_BASE);
    assign f7_alt  = (inst_i.r.funct7 == ex_pkg::F7_ALT);

    // shift amount sits in the low bits of the immediate
    assign imm_shamt = inst_i.i.imm[ex_pkg::SHAMT_W-1:0];
    assign reg_shamt = reg2_rdata_i[ex_pkg::SHAMT_W-1:0];

    always_comb begin
        alu_op_o  = ex_pkg::ALU_NONE;
        br_cond_o = ex_pkg::BR_NEVER;
        shamt_o   = '0;
        case (opcode)
            ex_pkg::OP_IMM: begin
                case (funct3)
                    ex_pkg::F3_ADD_SUB: alu_op_o = ex_pkg::ALU_ADD;
                    ex_pkg::F3_SLT:     alu_op_o = ex_pkg::ALU_SLT;
                    ex_pkg::F3_SLTU:    alu_op_o = ex_pkg::ALU_SLTU;
                    ex_pkg::F3_XOR:     alu_op_o = ex_pkg::ALU_XOR;
                    ex_pkg::F3_OR:      alu_op_o = ex_pkg::ALU_OR;
                    ex_pkg::F3_AND:     alu_op_o = ex_pkg::ALU_AND;
                    ex_pkg::F3_SLL: begin
                        if (f7_base) begin
                            alu_op_o = ex_pkg::ALU_SLL;
                            shamt_o  = imm_shamt;
                        end
                    end
                    default: begin
                        if (f7_base || f7_alt) begin
                            alu_op_o = f7_alt ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
                            shamt_o  = imm_shamt;
                        end
                    end
                endcase
            end
            ex_pkg::OP_REG: begin
                case (funct3)
                    ex_pkg::F3_ADD_SUB: begin
                        if (f7_base || f7_alt) begin
                            alu_op_o = f7_alt ? ex_pkg::ALU_SUB : ex_pkg::ALU_ADD;
                        end
                    end
                    ex_pkg::F3_SR: begin
                        if (f7_base || f7_alt) begin
                            alu_op_o = f7_alt ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
                            shamt_o  = reg_shamt;
                        end
                    end
                    ex_pkg::F3_SLL: begin
                        if (f7_base) begin
                            alu_op_o = ex_pkg::ALU_SLL;
                            shamt_o  = reg_shamt;
                        end
                    end
                    ex_pkg::F3_SLT:  alu_op_o = f7_base ? ex_pkg::ALU_SLT : ex_pkg::ALU_NONE;
                    ex_pkg::F3_SLTU: alu_op_o = f7_base ? ex_pkg::ALU_SLTU : ex_pkg::ALU_NONE;
                    ex_pkg::F3_XOR:  alu_op_o = f7_base ? ex_pkg::ALU_XOR : ex_pkg::ALU_NONE;
                    ex_pkg::F3_OR:   alu_op_o = f7_base ? ex_pkg::ALU_OR : ex_pkg::ALU_NONE;
                    default:         alu_op_o = f7_base ? ex_pkg::ALU_AND : ex_pkg::ALU_NONE;
                endcase
            end
            ex_pkg::OP_BRANCH: begin
                case (funct3)
                    ex_pkg::F3_BEQ:  br_cond_o = ex_pkg::BR_EQ;
                    ex_pkg::F3_BNE:  br_cond_o = ex_pkg::BR_NE;
                    ex_pkg::F3_BLT:  br_cond_o = ex_pkg::BR_LT;
                    ex_pkg::F3_BGE:  br_cond_o = ex_pkg::BR_GE;
                    ex_pkg::F3_BLTU: br_cond_o = ex_pkg::BR_LTU;
                    ex_pkg::F3_BGEU: br_cond_o = ex_pkg::BR_GEU;
                    default:         br_cond_o = ex_pkg::BR_NEVER;
                endcase
            end
            // link value is op1+op2, prepared by decode
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: begin
                alu_op_o  = ex_pkg::ALU_ADD;
                br_cond_o = ex_pkg::BR_ALWAYS;
            end
            ex_pkg::OP_LUI, ex_pkg::OP_AUIPC: alu_op_o = ex_pkg::ALU_ADD;
            default: alu_op_o = ex_pkg::ALU_NONE;
        endcase
    end

    // a fully known instruction never leaves the controls undecided
    always_comb begin
        if (!$isunknown({inst_i, reg2_rdata_i})) begin
            assert final (!$isunknown({alu_op_o, br_cond_o, shamt_o}))
                else $error("decode left controls unknown for %h", inst_i);
        end
    end

endmodule

/* logic/ex_result_if.sv */
`timescale 1ns/1ps

// one cycle of execute results on their way to the pipeline register
interface ex_result_if;

    ex_pkg::word_t     wdata;
    logic              we;
    ex_pkg::reg_addr_t waddr;
    logic              jump;
    ex_pkg::word_t     jump_addr;

    modport alu (
        output wdata,
        output we,
        output waddr,
        output jump,
        output jump_addr
    );

    modport reg_stage (
        input wdata,
        input we,
        input waddr,
        input jump,
        input jump_addr
    );

endinterface

/* logic/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;

    // major opcodes handled by this stage
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alt form selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NEVER, BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    // register view and immediate view of the same word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
    } inst_t;

endpackage
